//--- dv/pipe_model.svh
/*
 * Reference model for the pipeline testbench
 * Sequential ISA model, load data hash and the random number step
 */
`ifndef PIPE_MODEL_SVH
`define PIPE_MODEL_SVH

// Architectural state of the model, r0 is never written
logic [DATA_W-1:0] model_regs [8];

// Next state of a 32-bit linear congruential generator
function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// Load data, every address bit mixes into the result
function automatic logic [DATA_W-1:0] mem_hash(input logic [DATA_W-1:0] addr);
  logic [DATA_W-1:0] mix;
  mix = addr * 16'h9e37;
  return mix ^ {addr[7:0], addr[15:8]} ^ 16'h5a3c;
endfunction

// True when the word reads register r as a source
function automatic logic reads_reg(input logic [15:0] word, input logic [2:0] r);
  case (word[15:12])
    OP_ADD, OP_SUB, OP_AND, OP_XOR: return (word[8:6] == r) || (word[5:3] == r);
    OP_ADDI, OP_LD:                 return word[8:6] == r;
    default:                        return 1'b0;
  endcase
endfunction

// Executes one word in program order on the model registers
function automatic void exec_instr(
  input  logic [15:0]       word,
  output logic              we,
  output logic [2:0]        rd,
  output logic [DATA_W-1:0] val,
  output logic              is_ld,
  output logic [DATA_W-1:0] addr
);
  logic [DATA_W-1:0] a;
  logic [DATA_W-1:0] b;
  logic [DATA_W-1:0] imm;
  rd    = word[11:9];
  a     = model_regs[word[8:6]];
  b     = model_regs[word[5:3]];
  // I format immediate, sign extended from bit 5
  imm   = {{(DATA_W-6){word[5]}}, word[5:0]};
  addr  = a + imm;
  we    = 1'b1;
  is_ld = 1'b0;
  val   = '0;
  case (word[15:12])
    OP_ADD:  val = a + b;
    OP_SUB:  val = a - b;
    OP_AND:  val = a & b;
    OP_XOR:  val = a ^ b;
    OP_ADDI: val = addr;
    OP_LD: begin
      is_ld = 1'b1;
      val   = mem_hash(addr);
    end
    default: we = 1'b0;
  endcase
  // Writes to r0 are dropped
  if (rd == 3'd0) begin
    we = 1'b0;
  end
  if (we) begin
    model_regs[rd] = val;
  end
endfunction

`endif

//--- dv/pipe_tb.sv
/*
 * Testbench for the three-stage pipeline
 * Random program, memory responder with random latency and a
 * retirement checker against a sequential model
 */
`timescale 1ns/1ps
`default_nettype none

module pipe_tb;
  import pipe_pkg::*;

  localparam int DATA_W         = 16;
  localparam int NUM_INSTR      = 400;
  localparam int ACCEPT_TIMEOUT = 40;
  localparam int DRAIN_TIMEOUT  = 200;

  logic              clk = 1'b0;
  logic              rst_n_i;
  logic              instr_valid_i;
  logic [15:0]       instr_i;
  logic              instr_ready_o;
  logic              mem_req_o;
  logic [DATA_W-1:0] mem_addr_o;
  logic              mem_rvalid_i;
  logic [DATA_W-1:0] mem_rdata_i;
  logic              wb_we_o;
  logic [REG_AW-1:0] wb_waddr_o;
  logic [DATA_W-1:0] wb_wdata_o;

  // Stimulus applied at the next drive point
  logic        next_valid;
  logic [15:0] next_instr;
  logic        accepted;
  int unsigned cycle_cnt;
  logic [31:0] rng_state;

  // Expected writebacks and load addresses in program order
  logic [REG_AW-1:0] exp_waddr_q [$];
  logic [DATA_W-1:0] exp_wdata_q [$];
  logic [DATA_W-1:0] exp_addr_q [$];
  // Requested loads not yet answered and their remaining latency
  logic [DATA_W-1:0] pend_addr_q [$];
  int unsigned       pend_lat_q [$];

  `include "pipe_model.svh"

  pipe_top #(.DATA_W(DATA_W)) uut (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .instr_ready_o (instr_ready_o),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i),
    .wb_we_o       (wb_we_o),
    .wb_waddr_o    (wb_waddr_o),
    .wb_wdata_o    (wb_wdata_o)
  );

  always #20 clk = ~clk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t: %s got %0h expected %0h", $time, name, got, exp));
    end
  endtask

  function automatic int unsigned rand_below(input int unsigned n);
    rng_state = lcg_next(rng_state);
    return rng_state[31:16] % n;
  endfunction

  // Weighted opcode mix with a few NOP encodings
  function automatic logic [15:0] gen_instr();
    logic [3:0]  op;
    logic [2:0]  rd;
    logic [2:0]  rs1;
    logic [5:0]  low;
    int unsigned pick;
    pick = rand_below(16);
    case (pick)
      0, 1:      op = OP_ADD;
      2, 3:      op = OP_SUB;
      4, 5:      op = OP_AND;
      6, 7:      op = OP_XOR;
      8, 9, 10:  op = OP_ADDI;
      11, 12, 13: op = OP_LD;
      14:        op = 4'h0;
      default:   op = 4'(7 + rand_below(9));
    endcase
    rd  = 3'(rand_below(8));
    rs1 = 3'(rand_below(8));
    // rs2 and spare bits or the immediate
    low = 6'(rand_below(64));
    return {op, rd, rs1, low};
  endfunction

  // Answers the oldest request once its latency runs out
  task automatic drive_memory();
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    if (pend_addr_q.size() != 0) begin
      if (pend_lat_q[0] == 0) begin
        mem_rvalid_i = 1'b1;
        mem_rdata_i  = mem_hash(pend_addr_q.pop_front());
        void'(pend_lat_q.pop_front());
      end else begin
        pend_lat_q[0] = pend_lat_q[0] - 1;
      end
    end
  endtask

  task automatic sample_outputs();
    logic              we;
    logic [REG_AW-1:0] rd;
    logic [DATA_W-1:0] val;
    logic              is_ld;
    logic [DATA_W-1:0] addr;
    // Retirement in program order
    if (wb_we_o) begin
      if (exp_waddr_q.size() == 0) begin
        abort_run("writeback seen with no instruction outstanding");
      end else begin
        check_value("wb_waddr_o", wb_waddr_o, exp_waddr_q.pop_front());
        check_value("wb_wdata_o", wb_wdata_o, exp_wdata_q.pop_front());
      end
    end
    // One request per load
    if (mem_req_o) begin
      if (exp_addr_q.size() == 0) begin
        abort_run("memory request seen with no load outstanding");
      end else begin
        addr = exp_addr_q.pop_front();
        check_value("mem_addr_o", mem_addr_o, addr);
        pend_addr_q.push_back(addr);
        pend_lat_q.push_back(rand_below(5));
      end
    end
    accepted = instr_valid_i && instr_ready_o;
    if (accepted) begin
      exec_instr(instr_i, we, rd, val, is_ld, addr);
      if (we) begin
        exp_waddr_q.push_back(rd);
        exp_wdata_q.push_back(val);
      end
      if (is_ld) begin
        exp_addr_q.push_back(addr);
      end
    end
  endtask

  // Drive after the rising edge and sample at the falling edge
  task automatic step_cycle();
    @(posedge clk);
    cycle_cnt++;
    #1;
    instr_valid_i = next_valid;
    instr_i       = next_instr;
    drive_memory();
    @(negedge clk);
    sample_outputs();
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int unsigned       waited;
    int unsigned       gap;
    int unsigned       prev_cycle;
    logic              prev_ld;
    logic [REG_AW-1:0] prev_ld_rd;
    logic              adjacent;
    logic              load_use;
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    mem_rvalid_i  = 1'b0;
    mem_rdata_i   = '0;
    next_valid    = 1'b0;
    next_instr    = '0;
    accepted      = 1'b0;
    cycle_cnt     = 0;
    rng_state     = 32'hcf9;
    prev_cycle    = 0;
    prev_ld       = 1'b0;
    prev_ld_rd    = '0;
    for (int r = 0; r < 8; r++) begin
      model_regs[r] = '0;
    end

    repeat (16) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    @(negedge clk);
    // Idle state after reset
    check_value("instr_ready_o", instr_ready_o, 1'b1);
    check_value("mem_req_o", mem_req_o, 1'b0);
    check_value("wb_we_o", wb_we_o, 1'b0);

    for (int n = 0; n < NUM_INSTR; n++) begin
      // Valid gap with junk on the instruction bus
      if (rand_below(4) == 0) begin
        gap = 1 + rand_below(3);
        for (int g = 0; g < gap; g++) begin
          next_valid = 1'b0;
          next_instr = 16'(rand_below(65536));
          step_cycle();
        end
      end
      next_valid = 1'b1;
      next_instr = gen_instr();
      adjacent   = (n != 0) && (cycle_cnt == prev_cycle);
      load_use   = adjacent && prev_ld && (prev_ld_rd != '0) &&
                   reads_reg(next_instr, prev_ld_rd);
      waited     = 0;
      step_cycle();
      // ALU results forward with no bubble
      if (!accepted && adjacent && !prev_ld && (pend_addr_q.size() == 0)) begin
        abort_run("instruction stalled behind an ALU result");
      end
      while (!accepted) begin
        waited++;
        if (waited > ACCEPT_TIMEOUT) begin
          abort_run("timeout waiting for instr_ready_o to accept an instruction");
        end
        step_cycle();
      end
      if (load_use && (waited == 0)) begin
        abort_run("load-use dependency accepted without a stall");
      end
      prev_cycle = cycle_cnt;
      prev_ld    = (next_instr[15:12] == OP_LD);
      prev_ld_rd = next_instr[11:9];
      next_valid = 1'b0;
    end

    // Drain writebacks and outstanding loads
    next_valid = 1'b0;
    waited     = 0;
    while ((exp_waddr_q.size() != 0) || (exp_addr_q.size() != 0) ||
           (pend_addr_q.size() != 0)) begin
      waited++;
      if (waited > DRAIN_TIMEOUT) begin
        abort_run("timeout waiting for the pipeline to drain");
      end
      step_cycle();
    end
    // Quiet cycles catch late or duplicated writebacks
    repeat (8) begin
      step_cycle();
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/bypass_ctrl.sv
/*
 * Bypass and hazard controller
 * Compares ID read addresses with EX and WB write addresses,
 * generates operand forwarding selects and the load-use stall
 */
`timescale 1ns/1ps
`default_nettype none

module bypass_ctrl (
  // Read side of the instruction in ID
  input  wire                        rf_re_a_i,
  input  wire                        rf_re_b_i,
  input  wire [pipe_pkg::REG_AW-1:0] rf_raddr_a_i,
  input  wire [pipe_pkg::REG_AW-1:0] rf_raddr_b_i,

  // Pipeline registers
  id_ex_if.mon                       id_ex,
  ex_wb_if.mon                       ex_wb,

  // Back to ID
  output logic [1:0]                 fw_sel_a_o,
  output logic [1:0]                 fw_sel_b_o,
  output logic                       load_stall_o
);
  import pipe_pkg::*;

  // Port 0 is operand a, port 1 is operand b
  logic [1:0]        rf_re;
  logic [REG_AW-1:0] rf_raddr [2];
  logic [1:0]        rd_ex_match;
  logic [1:0]        rd_wb_match;

  // Qualified write enables per stage
  logic rf_we_ex;
  logic rf_we_wb;
  logic load_ex;

  // Priority pick for one operand, EX is the younger result
  function automatic logic [1:0] fw_pick(
    input logic ex_hit,
    input logic wb_hit
  );
    logic [1:0] sel;
    sel = FW_REGFILE;
    if (wb_hit) begin
      sel = FW_WB;
    end
    if (ex_hit) begin
      sel = FW_EX;
    end
    return sel;
  endfunction

  assign rf_re       = {rf_re_b_i, rf_re_a_i};
  assign rf_raddr[0] = rf_raddr_a_i;
  assign rf_raddr[1] = rf_raddr_b_i;

  assign rf_we_ex = id_ex.rf_we && id_ex.instr_valid;
  assign rf_we_wb = ex_wb.rf_we && ex_wb.instr_valid;

  // Load writing a register, data not known before WB
  assign load_ex  = rf_we_ex && id_ex.lsu_en;

  //////////////////////////////////////////////////
  // Address compare
  //////////////////////////////////////////////////

  for (genvar i = 0; i < 2; i++) begin : gen_match
    // Valid write to the same nonzero register, read enabled
    assign rd_ex_match[i] = rf_we_ex && (id_ex.rf_waddr == rf_raddr[i]) &&
                            (|rf_raddr[i]) && rf_re[i];
    assign rd_wb_match[i] = rf_we_wb && (ex_wb.rf_waddr == rf_raddr[i]) &&
                            (|rf_raddr[i]) && rf_re[i];
  end

  //////////////////////////////////////////////////
  // Stall and forward selects
  //////////////////////////////////////////////////

  // One bubble, then the load result is taken from WB
  assign load_stall_o = load_ex && (|rd_ex_match);

  // EX select on a load is never used, the stall swallows it
  assign fw_sel_a_o = fw_pick(rd_ex_match[0], rd_wb_match[0]);
  assign fw_sel_b_o = fw_pick(rd_ex_match[1], rd_wb_match[1]);

endmodule

`default_nettype wire

//--- source/ex_stage.sv
/*
 * Execute stage
 * ALU, load address and request, and the EX/WB register
 */
`timescale 1ns/1ps
`default_nettype none

module ex_stage #(
  parameter int DATA_W = 16
) (
  input  wire               clk,
  input  wire               rst_n_i,
  id_ex_if.dst              id_ex,
  input  wire               wb_ready_i,
  output logic [DATA_W-1:0] ex_result_o,
  output logic              mem_req_o,
  output logic [DATA_W-1:0] mem_addr_o,
  ex_wb_if.src              ex_wb
);
  import pipe_pkg::*;

  logic [DATA_W-1:0] alu_result;
  // Request already issued for the load held in EX
  logic              req_sent_q;

  // Loads reuse the adder for rs1 plus imm
  always_comb begin
    case (id_ex.opcode)
      OP_ADD, OP_ADDI, OP_LD: alu_result = id_ex.operand_a + id_ex.operand_b;
      OP_SUB:                 alu_result = id_ex.operand_a - id_ex.operand_b;
      OP_AND:                 alu_result = id_ex.operand_a & id_ex.operand_b;
      OP_XOR:                 alu_result = id_ex.operand_a ^ id_ex.operand_b;
      default:                alu_result = '0;
    endcase
  end

  assign ex_result_o = alu_result;
  assign mem_addr_o  = alu_result;

  // Only the first EX cycle of a load requests
  assign mem_req_o = id_ex.instr_valid && id_ex.lsu_en && !req_sent_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      req_sent_q <= 1'b0;
    end else if (wb_ready_i) begin
      req_sent_q <= 1'b0;
    end else if (mem_req_o) begin
      req_sent_q <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ex_wb.instr_valid <= 1'b0;
      ex_wb.rf_we       <= 1'b0;
      ex_wb.lsu_en      <= 1'b0;
    end else if (wb_ready_i) begin
      ex_wb.instr_valid <= id_ex.instr_valid;
      ex_wb.rf_we       <= id_ex.rf_we;
      ex_wb.lsu_en      <= id_ex.lsu_en;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_ready_i) begin
      ex_wb.rf_waddr <= id_ex.rf_waddr;
      ex_wb.result   <= alu_result;
    end
  end

endmodule

`default_nettype wire

//--- source/id_stage.sv
/*
 * Decode and operand read stage
 * Decodes the instruction word, picks forwarded operands and
 * loads the ID/EX register, inserting bubbles on a load-use stall
 */
`timescale 1ns/1ps
`default_nettype none

module id_stage #(
  parameter int DATA_W = 16
) (
  input  wire                         clk,
  input  wire                         rst_n_i,

  // Instruction input
  input  wire                         instr_valid_i,
  input  wire [15:0]                  instr_i,
  output logic                        instr_ready_o,

  // Register file read side
  output logic [pipe_pkg::REG_AW-1:0] rf_raddr_a_o,
  output logic [pipe_pkg::REG_AW-1:0] rf_raddr_b_o,
  output logic                        rf_re_a_o,
  output logic                        rf_re_b_o,
  input  wire [DATA_W-1:0]            rf_rdata_a_i,
  input  wire [DATA_W-1:0]            rf_rdata_b_i,

  // From the bypass controller
  input  wire [1:0]                   fw_sel_a_i,
  input  wire [1:0]                   fw_sel_b_i,
  input  wire                         load_stall_i,

  // Forwarding sources and WB status
  input  wire                         wb_ready_i,
  input  wire [DATA_W-1:0]            ex_result_i,
  input  wire [DATA_W-1:0]            wb_wdata_i,

  id_ex_if.src                        id_ex
);
  import pipe_pkg::*;

  instr_u            instr;
  logic [3:0]        opcode;
  logic              is_r;
  logic              is_i;
  logic              accept;
  logic [DATA_W-1:0] imm_ext;
  logic [DATA_W-1:0] fw_a;
  logic [DATA_W-1:0] fw_b;

  function automatic logic [DATA_W-1:0] fw_mux(
    input logic [1:0]        sel,
    input logic [DATA_W-1:0] rf_val,
    input logic [DATA_W-1:0] ex_val,
    input logic [DATA_W-1:0] wb_val
  );
    logic [DATA_W-1:0] val;
    case (sel)
      FW_EX:   val = ex_val;
      FW_WB:   val = wb_val;
      default: val = rf_val;
    endcase
    return val;
  endfunction

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  assign instr  = instr_i;
  assign opcode = instr.r_fmt.opcode;

  assign is_r = (opcode == OP_ADD) || (opcode == OP_SUB) ||
                (opcode == OP_AND) || (opcode == OP_XOR);
  assign is_i = (opcode == OP_ADDI) || (opcode == OP_LD);

  // rs1 and rs2 sit at the same place in both formats
  assign rf_raddr_a_o = instr.r_fmt.rs1;
  assign rf_raddr_b_o = instr.r_fmt.rs2;

  // No reads while idle, avoids false stalls
  assign rf_re_a_o = instr_valid_i && (is_r || is_i);
  assign rf_re_b_o = instr_valid_i && is_r;

  assign imm_ext = {{(DATA_W-IMM_W){instr.i_fmt.imm6[IMM_W-1]}}, instr.i_fmt.imm6};

  // Operand selection
  assign fw_a = fw_mux(fw_sel_a_i, rf_rdata_a_i, ex_result_i, wb_wdata_i);
  assign fw_b = fw_mux(fw_sel_b_i, rf_rdata_b_i, ex_result_i, wb_wdata_i);

  // Held while WB waits or while a load result is pending
  assign instr_ready_o = !load_stall_i && wb_ready_i;
  assign accept        = instr_valid_i && instr_ready_o;

  //////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////

  // Bubble when nothing is accepted, hold while WB is frozen
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      id_ex.instr_valid <= 1'b0;
      id_ex.rf_we       <= 1'b0;
      id_ex.lsu_en      <= 1'b0;
    end else if (wb_ready_i) begin
      id_ex.instr_valid <= accept;
      id_ex.rf_we       <= accept && (is_r || is_i) && (instr.r_fmt.rd != '0);
      id_ex.lsu_en      <= accept && (opcode == OP_LD);
    end
  end

  always_ff @(posedge clk) begin
    if (wb_ready_i) begin
      id_ex.rf_waddr  <= instr.r_fmt.rd;
      id_ex.opcode    <= opcode;
      id_ex.operand_a <= fw_a;
      id_ex.operand_b <= is_i ? imm_ext : fw_b;
    end
  end

endmodule

`default_nettype wire

//--- source/pipe_if.sv
/*
 * Pipeline register bundles
 * id_ex_if carries the decoded instruction into EX,
 * ex_wb_if carries the EX result into WB
 */
`timescale 1ns/1ps
`default_nettype none

interface id_ex_if #(
  parameter int DATA_W = 16
);
  import pipe_pkg::*;

  logic              instr_valid;
  // Already cleared for rd == r0
  logic              rf_we;
  logic [REG_AW-1:0] rf_waddr;
  logic              lsu_en;
  logic [3:0]        opcode;
  logic [DATA_W-1:0] operand_a;
  // rs2 value or sign-extended immediate
  logic [DATA_W-1:0] operand_b;

  modport src (output instr_valid, rf_we, rf_waddr, lsu_en, opcode, operand_a, operand_b);
  modport dst (input  instr_valid, rf_we, rf_waddr, lsu_en, opcode, operand_a, operand_b);
  // Hazard detection only looks at the write side
  modport mon (input  instr_valid, rf_we, rf_waddr, lsu_en);

endinterface

interface ex_wb_if #(
  parameter int DATA_W = 16
);
  import pipe_pkg::*;

  logic              instr_valid;
  logic              rf_we;
  logic [REG_AW-1:0] rf_waddr;
  logic              lsu_en;
  // ALU value, or the load address
  logic [DATA_W-1:0] result;

  modport src (output instr_valid, rf_we, rf_waddr, lsu_en, result);
  modport dst (input  instr_valid, rf_we, rf_waddr, lsu_en, result);
  modport mon (input  instr_valid, rf_we, rf_waddr);

endinterface

`default_nettype wire

//--- source/pipe_pkg.sv
/*
 * Shared definitions for the three-stage integer pipeline
 * Instruction word layouts, opcodes, forwarding selects and
 * the register address width
 */
`default_nettype none

package pipe_pkg;

  // Eight architectural registers, r0 reads as zero
  localparam int REG_AW = 3;

  // Width of the I format immediate
  localparam int IMM_W = 6;

  //////////////////////////////////////////////////
  // Instruction word
  //////////////////////////////////////////////////

  // Both formats share opcode, rd and rs1 in the upper ten bits
  typedef union packed {
    struct packed {
      logic [3:0]        opcode;
      logic [REG_AW-1:0] rd;
      logic [REG_AW-1:0] rs1;
      logic [REG_AW-1:0] rs2;
      logic [2:0]        unused;
    } r_fmt;
    struct packed {
      logic [3:0]              opcode;
      logic [REG_AW-1:0]       rd;
      logic [REG_AW-1:0]       rs1;
      logic signed [IMM_W-1:0] imm6;
    } i_fmt;
  } instr_u;

  // R format opcodes
  localparam logic [3:0] OP_ADD  = 4'h1;
  localparam logic [3:0] OP_SUB  = 4'h2;
  localparam logic [3:0] OP_AND  = 4'h3;
  localparam logic [3:0] OP_XOR  = 4'h4;

  // I format opcodes, load address is rs1 plus imm
  localparam logic [3:0] OP_ADDI = 4'h5;
  localparam logic [3:0] OP_LD   = 4'h6;

  //////////////////////////////////////////////////
  // Operand forwarding selects
  //////////////////////////////////////////////////

  localparam logic [1:0] FW_REGFILE = 2'd0;
  localparam logic [1:0] FW_EX      = 2'd1;
  localparam logic [1:0] FW_WB      = 2'd2;

endpackage

`default_nettype wire

//--- source/pipe_top.sv
/*
 * Three-stage integer pipeline, ID, EX and WB
 * Connects the stages, the bypass controller and the register
 * file, and exposes the writeback port
 */
`timescale 1ns/1ps
`default_nettype none

module pipe_top #(
  parameter int DATA_W = 16
) (
  input  wire                         clk,
  input  wire                         rst_n_i,

  // Instruction stream
  input  wire                         instr_valid_i,
  input  wire [15:0]                  instr_i,
  output logic                        instr_ready_o,

  // Load memory
  output logic                        mem_req_o,
  output logic [DATA_W-1:0]           mem_addr_o,
  input  wire                         mem_rvalid_i,
  input  wire [DATA_W-1:0]            mem_rdata_i,

  // Writeback observation
  output logic                        wb_we_o,
  output logic [pipe_pkg::REG_AW-1:0] wb_waddr_o,
  output logic [DATA_W-1:0]           wb_wdata_o
);
  import pipe_pkg::*;

  logic [REG_AW-1:0] rf_raddr_a;
  logic [REG_AW-1:0] rf_raddr_b;
  logic              rf_re_a;
  logic              rf_re_b;
  logic [DATA_W-1:0] rf_rdata_a;
  logic [DATA_W-1:0] rf_rdata_b;
  logic [1:0]        fw_sel_a;
  logic [1:0]        fw_sel_b;
  logic              load_stall;
  logic [DATA_W-1:0] ex_result;
  logic              wb_ready;

  id_ex_if #(.DATA_W(DATA_W)) id_ex ();
  ex_wb_if #(.DATA_W(DATA_W)) ex_wb ();

  // Write port comes straight from WB
  regfile #(.DATA_W(DATA_W)) u_regfile (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .we_i      (wb_we_o),
    .waddr_i   (wb_waddr_o),
    .wdata_i   (wb_wdata_o)
  );

  bypass_ctrl u_bypass_ctrl (
    .rf_re_a_i    (rf_re_a),
    .rf_re_b_i    (rf_re_b),
    .rf_raddr_a_i (rf_raddr_a),
    .rf_raddr_b_i (rf_raddr_b),
    .id_ex        (id_ex.mon),
    .ex_wb        (ex_wb.mon),
    .fw_sel_a_o   (fw_sel_a),
    .fw_sel_b_o   (fw_sel_b),
    .load_stall_o (load_stall)
  );

  id_stage #(.DATA_W(DATA_W)) u_id_stage (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .instr_ready_o (instr_ready_o),
    .rf_raddr_a_o  (rf_raddr_a),
    .rf_raddr_b_o  (rf_raddr_b),
    .rf_re_a_o     (rf_re_a),
    .rf_re_b_o     (rf_re_b),
    .rf_rdata_a_i  (rf_rdata_a),
    .rf_rdata_b_i  (rf_rdata_b),
    .fw_sel_a_i    (fw_sel_a),
    .fw_sel_b_i    (fw_sel_b),
    .load_stall_i  (load_stall),
    .wb_ready_i    (wb_ready),
    .ex_result_i   (ex_result),
    .wb_wdata_i    (wb_wdata_o),
    .id_ex         (id_ex.src)
  );

  ex_stage #(.DATA_W(DATA_W)) u_ex_stage (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .id_ex       (id_ex.dst),
    .wb_ready_i  (wb_ready),
    .ex_result_o (ex_result),
    .mem_req_o   (mem_req_o),
    .mem_addr_o  (mem_addr_o),
    .ex_wb       (ex_wb.src)
  );

  wb_stage #(.DATA_W(DATA_W)) u_wb_stage (
    .ex_wb        (ex_wb.dst),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .wb_ready_o   (wb_ready),
    .wb_we_o      (wb_we_o),
    .wb_waddr_o   (wb_waddr_o),
    .wb_wdata_o   (wb_wdata_o)
  );

endmodule

`default_nettype wire

//--- source/regfile.sv
/*
 * Register file, two combinational read ports, one write port
 * r0 is hardwired to zero
 */
`timescale 1ns/1ps
`default_nettype none

module regfile #(
  parameter int DATA_W = 16
) (
  input  wire                        clk,
  input  wire                        rst_n_i,
  input  wire [pipe_pkg::REG_AW-1:0] raddr_a_i,
  input  wire [pipe_pkg::REG_AW-1:0] raddr_b_i,
  output logic [DATA_W-1:0]          rdata_a_o,
  output logic [DATA_W-1:0]          rdata_b_o,
  input  wire                        we_i,
  input  wire [pipe_pkg::REG_AW-1:0] waddr_i,
  input  wire [DATA_W-1:0]           wdata_i
);
  import pipe_pkg::*;

  localparam int NUM_REGS = 1 << REG_AW;

  logic [DATA_W-1:0] regs [NUM_REGS];

  // Entry 0 is never written
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // Old value on a same-cycle write, WB forwarding covers it
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

`default_nettype wire

//--- source/wb_stage.sv
/*
 * Writeback stage
 * Waits for load data, selects the write-back value and
 * drives the register file write port
 */
`timescale 1ns/1ps
`default_nettype none

module wb_stage #(
  parameter int DATA_W = 16
) (
  ex_wb_if.dst                        ex_wb,

  // Load data return
  input  wire                         mem_rvalid_i,
  input  wire [DATA_W-1:0]            mem_rdata_i,

  // Pipeline freeze while a load waits
  output logic                        wb_ready_o,

  // Register file write port
  output logic                        wb_we_o,
  output logic [pipe_pkg::REG_AW-1:0] wb_waddr_o,
  output logic [DATA_W-1:0]           wb_wdata_o
);

  logic load_wb;

  // Any load, even to r0, still consumes its response
  assign load_wb = ex_wb.instr_valid && ex_wb.lsu_en;

  // The rvalid cycle completes the load
  assign wb_ready_o = !load_wb || mem_rvalid_i;

  // EX/WB advances right after, so one pulse per instruction
  assign wb_we_o    = ex_wb.instr_valid && ex_wb.rf_we && wb_ready_o;
  assign wb_waddr_o = ex_wb.rf_waddr;

  // Memory data for loads, ALU value otherwise
  assign wb_wdata_o = ex_wb.lsu_en ? mem_rdata_i : ex_wb.result;

endmodule

`default_nettype wire

//--- verilog.f
+incdir+dv
source/pipe_pkg.sv
source/pipe_if.sv
source/regfile.sv
source/bypass_ctrl.sv
source/id_stage.sv
source/ex_stage.sv
source/wb_stage.sv
source/pipe_top.sv
dv/pipe_tb.sv
